/* turf_regs.f */
verilog/turf_regs_pkg.sv
verilog/turf_reg_decode.sv
verilog/turf_id_ctrl.sv
verilog/turf_crate_bridge.sv
verilog/turf_reg_result.sv
verilog/turf_regs_top.sv
testbench/turf_regs_clkgen.sv
testbench/turf_regs_tb.sv

/* Bender.yml */
package:
  name: turf_regs

sources:
  - verilog/turf_regs_pkg.sv
  - verilog/turf_reg_decode.sv
  - verilog/turf_id_ctrl.sv
  - verilog/turf_crate_bridge.sv
  - verilog/turf_reg_result.sv
  - verilog/turf_regs_top.sv
  - target: simulation
    files:
      - testbench/turf_regs_clkgen.sv
      - testbench/turf_regs_tb.sv

/* testbench/turf_regs_tb.sv */
`timescale 1ns/1ns
module turf_regs_tb;
    import turf_regs_pkg::*;

    localparam logic [31:0] IDENT_VAL   = "TURF";
    localparam logic [31:0] DATEVER_VAL = 32'h0103_0B2C;
    localparam int          TIMEOUT_CYC = 40;
    localparam int          ACK_LIMIT   = 200;
    localparam wb_addr_t    ID_ADR      = 28'h000_0000;
    localparam wb_addr_t    DV_ADR      = 28'h000_0004;
    localparam wb_addr_t    CTRL_ADR    = 28'h000_0008;
    localparam wb_addr_t    STAT_ADR    = 28'h000_000C;
    localparam wb_addr_t    CRATE_ADR   = 28'h800_0000;

    // Register access, refused link, answered link, silent link
    typedef enum logic [1:0] {K_REG, K_REFUSED, K_LINK, K_SILENT} kind_e;

    typedef struct packed {
        logic         we;
        kind_e        kind;
        link_mask_t   link_up;
        bridge_link_t link;
        wb_addr_t     addr;
        wb_data_t     wdata;
        wb_data_t     exp_data;
    } entry_t;

    logic ps_clk, reset_i, wb_stb_i, wb_we_i, wb_ack_o;
    logic cmd_valid_o, cmd_we_o, resp_valid_i;
    wb_addr_t     wb_adr_i;
    wb_data_t     wb_dat_i, wb_dat_o, cmd_data_o, resp_data_i;
    link_mask_t   link_up_i;
    bridge_link_t cmd_link_o;
    crate_addr_t  cmd_addr_o;

    entry_t       stim_q[$];
    int           errors = 0;
    int           cmd_count = 0;
    int           resp_delay = 0;
    bit           silent_mode = 1'b0;
    logic         seen_we;
    bridge_link_t seen_link;
    crate_addr_t  seen_addr;
    wb_data_t     seen_data;

    turf_regs_clkgen u_clkgen (.clk_o(ps_clk), .reset_o(reset_i));

    turf_regs_top #(
        .IDENT          (IDENT_VAL),
        .DATEVERSION    (DATEVER_VAL),
        .BRIDGE_TIMEOUT (TIMEOUT_CYC)
    ) turf_regs_top_inst (.*);

    // Link read data holds the address with the link number on top
    function automatic wb_data_t link_read_word(bridge_link_t link, crate_addr_t addr);
        return {link, 3'b000, addr};
    endfunction

    task automatic add_entry(input logic we, input wb_addr_t addr, input wb_data_t wdata,
                             input kind_e kind, input link_mask_t up, input bridge_link_t link,
                             input wb_data_t exp_data);
        entry_t e;
        e = {we, kind, up, link, addr, wdata, exp_data};
        if (kind == K_LINK && !we) begin
            e.exp_data = link_read_word(link, addr[26:0]);
        end
        stim_q.push_back(e);
    endtask

    task automatic check_data(input string name, input wb_data_t got, input wb_data_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_mask(input string name, input link_mask_t got, input link_mask_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_cmd(input logic we, input bridge_link_t link, input crate_addr_t addr,
                             input wb_data_t data);
        if ({seen_we, seen_link, seen_addr, seen_data} !== {we, link, addr, data}) begin
            errors++;
            $display("Error cmd_we/link/addr/data: got %h %h %h %h, expected %h %h %h %h",
                     seen_we, seen_link, seen_addr, seen_data, we, link, addr, data);
        end
    endtask

    // One bus access that starts and ends 2 ns after a rising edge
    task automatic run_access(input entry_t e, output wb_data_t rdata, output int lat,
                              output bit ok);
        ok = 1'b0;
        lat = -1;
        rdata = '0;
        wb_stb_i = 1'b1;
        wb_we_i = e.we;
        wb_adr_i = e.addr;
        wb_dat_i = e.wdata;
        for (int n = 0; n < ACK_LIMIT && !ok; n++) begin
            @(posedge ps_clk);
            #1;
            lat++;
            if (wb_ack_o) begin
                ok = 1'b1;
                rdata = wb_dat_o;
            end
        end
        #1;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        @(posedge ps_clk);
        #2;
        if (ok && wb_ack_o) begin
            errors++;
            $display("Ack stayed high for more than one cycle");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Link responder model
    ////////////////////////////////////////////////////////////

    initial begin : link_responder
        int unsigned delay;
        void'($urandom(72));
        resp_valid_i = 1'b0;
        resp_data_i  = '0;
        forever begin
            @(posedge ps_clk);
            #1;
            if (!reset_i && cmd_valid_o) begin
                cmd_count++;
                seen_we   = cmd_we_o;
                seen_link = cmd_link_o;
                seen_addr = cmd_addr_o;
                seen_data = cmd_data_o;
                if (!silent_mode) begin
                    delay = $urandom_range(10, 1);
                    resp_delay = delay;
                    #1;
                    repeat (delay - 1) begin
                        @(posedge ps_clk);
                        #2;
                    end
                    resp_valid_i = 1'b1;
                    resp_data_i  = seen_we ? '0 : link_read_word(seen_link, seen_addr);
                    @(posedge ps_clk);
                    #2;
                    resp_valid_i = 1'b0;
                    resp_data_i  = '0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus table and main loop
    ////////////////////////////////////////////////////////////

    initial begin : main
        entry_t   e;
        wb_data_t rdata;
        int       lat;
        int       cmd_before;
        bit       ok;
        bit       lat_ok;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        wb_adr_i  = '0;
        wb_dat_i  = '0;
        link_up_i = 4'hF;
        // ID and version registers ignore writes
        add_entry(1'b0, ID_ADR, '0, K_REG, 4'hF, 2'd0, IDENT_VAL);
        add_entry(1'b0, DV_ADR, '0, K_REG, 4'hF, 2'd0, DATEVER_VAL);
        add_entry(1'b1, ID_ADR, 32'hDEAD_BEEF, K_REG, 4'hF, 2'd0, '0);
        add_entry(1'b1, DV_ADR, 32'h1234_5678, K_REG, 4'hF, 2'd0, '0);
        add_entry(1'b0, ID_ADR, '0, K_REG, 4'hF, 2'd0, IDENT_VAL);
        add_entry(1'b0, DV_ADR, '0, K_REG, 4'hF, 2'd0, DATEVER_VAL);
        // Link select followed by forwarded crate accesses
        add_entry(1'b1, CTRL_ADR, 32'h2, K_REG, 4'hF, 2'd0, '0);
        add_entry(1'b0, CTRL_ADR, '0, K_REG, 4'hF, 2'd0, 32'h2);
        add_entry(1'b1, CRATE_ADR | 28'h000_1234, 32'hA5A5_0001, K_LINK, 4'hF, 2'd2, '0);
        add_entry(1'b0, CRATE_ADR | 28'h012_3458, '0, K_LINK, 4'hF, 2'd2, '0);
        add_entry(1'b0, CRATE_ADR | 28'h7FF_FFFC, '0, K_LINK, 4'hF, 2'd2, '0);
        // Refused link 1 and silent link 3 set the sticky flags
        add_entry(1'b1, CTRL_ADR, 32'h1, K_REG, 4'hF, 2'd0, '0);
        add_entry(1'b0, CRATE_ADR | 28'h000_0040, '0, K_REFUSED, 4'b1101, 2'd1, '0);
        add_entry(1'b0, STAT_ADR, '0, K_REG, 4'hF, 2'd0, 32'h20);
        add_entry(1'b1, CTRL_ADR, 32'h3, K_REG, 4'hF, 2'd0, '0);
        add_entry(1'b0, CRATE_ADR | 28'h000_0100, '0, K_SILENT, 4'hF, 2'd3, '0);
        add_entry(1'b0, STAT_ADR, '0, K_REG, 4'hF, 2'd0, 32'h28);
        // Event control, GbE, Aurora, TURFIO control
        add_entry(1'b0, 28'h000_4000, '0, K_REG, 4'hF, 2'd0, 32'h0);
        add_entry(1'b1, 28'h000_8008, 32'h0, K_REG, 4'hF, 2'd0, '0);
        add_entry(1'b1, 28'h000_C00C, 32'hFF, K_REG, 4'hF, 2'd0, '0);
        add_entry(1'b0, 28'h001_0008, '0, K_REG, 4'hF, 2'd0, 32'h0);
        // Dummy writes leave the link and the flags alone
        add_entry(1'b0, CTRL_ADR, '0, K_REG, 4'hF, 2'd0, 32'h3);
        add_entry(1'b0, STAT_ADR, '0, K_REG, 4'hF, 2'd0, 32'h28);
        // Writing ones clears the flags
        add_entry(1'b1, STAT_ADR, 32'hFF, K_REG, 4'hF, 2'd0, '0);
        add_entry(1'b0, STAT_ADR, '0, K_REG, 4'hF, 2'd0, 32'h0);

        ok = 1'b0;
        for (int n = 0; n < 50 && !ok; n++) begin
            @(posedge ps_clk);
            ok = !reset_i;
        end
        if (!ok) begin
            errors++;
            $display("Reset was never released");
        end
        #2;
        for (int i = 0; i < stim_q.size() && ok; i++) begin
            e = stim_q[i];
            silent_mode = (e.kind == K_SILENT);
            link_up_i = e.link_up;
            cmd_before = cmd_count;
            run_access(e, rdata, lat, ok);
            if (!ok) begin
                errors++;
                $display("No ack within %0d cycles at entry %0d", ACK_LIMIT, i);
            end else begin
                if (!e.we && e.addr == STAT_ADR) begin
                    check_mask("timeout flags", rdata[3:0], e.exp_data[3:0]);
                    check_mask("invalid flags", rdata[7:4], e.exp_data[7:4]);
                end else if (!e.we) begin
                    check_data("wb_dat_o", rdata, e.exp_data);
                end
                if (e.kind == K_LINK || e.kind == K_SILENT) begin
                    if (cmd_count != cmd_before + 1) begin
                        errors++;
                        $display("Expected one link command at entry %0d", i);
                    end
                    check_cmd(e.we, e.link, e.addr[26:0], e.wdata);
                end else if (cmd_count != cmd_before) begin
                    errors++;
                    $display("Unexpected link command at entry %0d", i);
                end
                case (e.kind)
                    K_REG:     lat_ok = (lat == 2);
                    K_REFUSED: lat_ok = (lat == 3);
                    K_LINK:    lat_ok = (lat == resp_delay + 2);
                    default:   lat_ok = (lat >= TIMEOUT_CYC + 2) && (lat <= TIMEOUT_CYC + 4);
                endcase
                if (!lat_ok) begin
                    errors++;
                    $display("Ack came %0d cycles after the strobe at entry %0d", lat, i);
                end
            end
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end
endmodule

/* testbench/turf_regs_clkgen.sv */
`timescale 1ns/1ns
module turf_regs_clkgen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic reset_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release off the edge so the first sampled edge is clean
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2 reset_o = 1'b0;
    end
endmodule

/* verilog/turf_regs_top.sv */
`timescale 1ns/1ns
module turf_regs_top #(
    parameter logic [31:0] IDENT          = "TURF",
    parameter logic [31:0] DATEVERSION    = 32'h0000_0000,
    parameter int          BRIDGE_TIMEOUT = 255
) (
    input  logic                        ps_clk,
    input  logic                        reset_i,
    // Register port from the processor bridge
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  turf_regs_pkg::wb_addr_t     wb_adr_i,
    input  turf_regs_pkg::wb_data_t     wb_dat_i,
    output logic                        wb_ack_o,
    output turf_regs_pkg::wb_data_t     wb_dat_o,
    // TURFIO link side
    input  turf_regs_pkg::link_mask_t   link_up_i,
    output logic                        cmd_valid_o,
    output logic                        cmd_we_o,
    output turf_regs_pkg::bridge_link_t cmd_link_o,
    output turf_regs_pkg::crate_addr_t  cmd_addr_o,
    output turf_regs_pkg::wb_data_t     cmd_data_o,
    input  logic                        resp_valid_i,
    input  turf_regs_pkg::wb_data_t     resp_data_i
);
    import turf_regs_pkg::*;

    reg_req_t     req;
    reg_rsp_t     id_rsp;
    reg_rsp_t     bridge_rsp;
    bridge_link_t bridge_link;
    link_mask_t   bridge_timeout;
    link_mask_t   bridge_invalid;

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    turf_reg_decode u_decode (
        .ps_clk   (ps_clk),
        .reset_i  (reset_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .done_i   (wb_ack_o),
        .req_o    (req)
    );

    ////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////

    turf_id_ctrl #(
        .IDENT       (IDENT),
        .DATEVERSION (DATEVERSION)
    ) u_idctrl (
        .ps_clk        (ps_clk),
        .reset_i       (reset_i),
        .req_i         (req),
        .rsp_o         (id_rsp),
        .bridge_link_o (bridge_link),
        .timeout_i     (bridge_timeout),
        .invalid_i     (bridge_invalid)
    );

    turf_crate_bridge #(
        .BRIDGE_TIMEOUT (BRIDGE_TIMEOUT)
    ) u_bridge (
        .ps_clk        (ps_clk),
        .reset_i       (reset_i),
        .req_i         (req),
        .bridge_link_i (bridge_link),
        .link_up_i     (link_up_i),
        .cmd_valid_o   (cmd_valid_o),
        .cmd_we_o      (cmd_we_o),
        .cmd_link_o    (cmd_link_o),
        .cmd_addr_o    (cmd_addr_o),
        .cmd_data_o    (cmd_data_o),
        .resp_valid_i  (resp_valid_i),
        .resp_data_i   (resp_data_i),
        .rsp_o         (bridge_rsp),
        .timeout_o     (bridge_timeout),
        .invalid_o     (bridge_invalid)
    );

    // Result merge whose ack also frees the decoder
    turf_reg_result u_result (
        .ps_clk       (ps_clk),
        .reset_i      (reset_i),
        .req_i        (req),
        .id_rsp_i     (id_rsp),
        .bridge_rsp_i (bridge_rsp),
        .wb_ack_o     (wb_ack_o),
        .wb_dat_o     (wb_dat_o)
    );

endmodule

/* verilog/turf_reg_result.sv */
`timescale 1ns/1ns
module turf_reg_result (
    input  logic                    ps_clk,
    input  logic                    reset_i,
    input  turf_regs_pkg::reg_req_t req_i,
    input  turf_regs_pkg::reg_rsp_t id_rsp_i,
    input  turf_regs_pkg::reg_rsp_t bridge_rsp_i,
    output logic                    wb_ack_o,
    output turf_regs_pkg::wb_data_t wb_dat_o
);
    import turf_regs_pkg::*;

    logic dummy_hit;
    logic dummy_valid;

    // Unimplemented spaces read zero and drop writes
    assign dummy_hit = req_i.valid && (req_i.space == SPACE_DUMMY);

    ////////////////////////////////////////////////////////////
    // Response merge
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (id_rsp_i.valid) begin
            wb_dat_o <= id_rsp_i.rdata;
        end else if (bridge_rsp_i.valid) begin
            wb_dat_o <= bridge_rsp_i.rdata;
        end else begin
            // Dummy answer or idle
            wb_dat_o <= '0;
        end
        if (reset_i) begin
            dummy_valid <= 1'b0;
            wb_ack_o    <= 1'b0;
        end else begin
            dummy_valid <= dummy_hit;
            wb_ack_o    <= id_rsp_i.valid | bridge_rsp_i.valid | dummy_valid;
        end
    end

    // Only one block may answer a given access
    a_single_rsp: assert property (
        @(posedge ps_clk) disable iff (reset_i)
        $onehot0({id_rsp_i.valid, bridge_rsp_i.valid, dummy_valid})
    );

endmodule

/* verilog/turf_crate_bridge.sv */
`timescale 1ns/1ns
module turf_crate_bridge #(
    parameter int BRIDGE_TIMEOUT = 255
) (
    input  logic                        ps_clk,
    input  logic                        reset_i,
    input  turf_regs_pkg::reg_req_t     req_i,
    input  turf_regs_pkg::bridge_link_t bridge_link_i,
    input  turf_regs_pkg::link_mask_t   link_up_i,
    output logic                        cmd_valid_o,
    output logic                        cmd_we_o,
    output turf_regs_pkg::bridge_link_t cmd_link_o,
    output turf_regs_pkg::crate_addr_t  cmd_addr_o,
    output turf_regs_pkg::wb_data_t     cmd_data_o,
    input  logic                        resp_valid_i,
    input  turf_regs_pkg::wb_data_t     resp_data_i,
    output turf_regs_pkg::reg_rsp_t     rsp_o,
    output turf_regs_pkg::link_mask_t   timeout_o,
    output turf_regs_pkg::link_mask_t   invalid_o
);
    import turf_regs_pkg::*;

    localparam int CNT_W = $clog2(BRIDGE_TIMEOUT + 1);

    bridge_state_e    state;
    logic [CNT_W-1:0] wait_cnt;
    logic             hit;
    logic             link_ok;
    reg_rsp_t         rsp_q;

    assign hit     = req_i.valid && (req_i.space == SPACE_CRATE);
    assign link_ok = link_up_i[bridge_link_i];

    ////////////////////////////////////////////////////////////
    // Command payload and response data
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (hit && (state == BR_IDLE)) begin
            cmd_we_o   <= req_i.we;
            cmd_link_o <= bridge_link_i;
            cmd_addr_o <= req_i.addr[CRATE_SEL_BIT-1:0];
            cmd_data_o <= req_i.wdata;
        end
        if ((state == BR_WAIT) && resp_valid_i) begin
            rsp_q.rdata <= resp_data_i;
        end else if (state == BR_DONE) begin
            // Error path answers with zero
            rsp_q.rdata <= '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Bridge FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            state       <= BR_IDLE;
            wait_cnt    <= '0;
            cmd_valid_o <= 1'b0;
            rsp_q.valid <= 1'b0;
            timeout_o   <= '0;
            invalid_o   <= '0;
        end else begin
            cmd_valid_o <= 1'b0;
            rsp_q.valid <= 1'b0;
            timeout_o   <= '0;
            invalid_o   <= '0;
            case (state)
                BR_IDLE: begin
                    if (hit) begin
                        if (link_ok) begin
                            cmd_valid_o <= 1'b1;
                            wait_cnt    <= '0;
                            state       <= BR_WAIT;
                        end else begin
                            // Refused without a command while the link is down
                            invalid_o[bridge_link_i] <= 1'b1;
                            state                    <= BR_DONE;
                        end
                    end
                end
                BR_WAIT: begin
                    if (resp_valid_i) begin
                        rsp_q.valid <= 1'b1;
                        state       <= BR_IDLE;
                    end else if (wait_cnt == CNT_W'(BRIDGE_TIMEOUT)) begin
                        timeout_o[cmd_link_o] <= 1'b1;
                        state                 <= BR_DONE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                BR_DONE: begin
                    rsp_q.valid <= 1'b1;
                    state       <= BR_IDLE;
                end
                default: begin
                    state <= BR_IDLE;
                end
            endcase
        end
    end

    assign rsp_o = rsp_q;

    a_cmd_single: assert property (
        @(posedge ps_clk) disable iff (reset_i)
        cmd_valid_o |=> !cmd_valid_o
    );

endmodule

/* verilog/turf_id_ctrl.sv */
`timescale 1ns/1ns
module turf_id_ctrl #(
    parameter logic [31:0] IDENT       = "TURF",
    parameter logic [31:0] DATEVERSION = 32'h0000_0000
) (
    input  logic                        ps_clk,
    input  logic                        reset_i,
    input  turf_regs_pkg::reg_req_t     req_i,
    output turf_regs_pkg::reg_rsp_t     rsp_o,
    output turf_regs_pkg::bridge_link_t bridge_link_o,
    input  turf_regs_pkg::link_mask_t   timeout_i,
    input  turf_regs_pkg::link_mask_t   invalid_i
);
    import turf_regs_pkg::*;

    // Word index covers address bits 13:2
    localparam int IDX_W = IDCTL_SEL_LSB - 2;

    logic             hit;
    logic [IDX_W-1:0] word_idx;
    logic             ctrl_wr;
    logic             stat_wr;
    wb_data_t         rd_data;
    link_mask_t       timeout_flags;
    link_mask_t       invalid_flags;
    link_mask_t       timeout_clr;
    link_mask_t       invalid_clr;
    reg_rsp_t         rsp_q;

    assign hit      = req_i.valid && (req_i.space == SPACE_IDCTL);
    assign word_idx = req_i.addr[IDCTL_SEL_LSB-1:2];
    assign ctrl_wr  = hit && req_i.we && (word_idx == IDX_W'(REG_BRIDGE_CTRL));
    assign stat_wr  = hit && req_i.we && (word_idx == IDX_W'(REG_BRIDGE_STAT));

    // Write-one-to-clear on the status word
    assign timeout_clr = stat_wr ? req_i.wdata[3:0] : '0;
    assign invalid_clr = stat_wr ? req_i.wdata[7:4] : '0;

    ////////////////////////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (word_idx)
            IDX_W'(REG_IDENT):       rd_data = IDENT;
            IDX_W'(REG_DATEVERSION): rd_data = DATEVERSION;
            IDX_W'(REG_BRIDGE_CTRL): rd_data = {30'b0, bridge_link_o};
            IDX_W'(REG_BRIDGE_STAT): rd_data = {24'b0, invalid_flags, timeout_flags};
            default:                 rd_data = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (hit) begin
            rsp_q.rdata <= rd_data;
        end
        if (reset_i) begin
            rsp_q.valid   <= 1'b0;
            bridge_link_o <= '0;
            timeout_flags <= '0;
            invalid_flags <= '0;
        end else begin
            rsp_q.valid <= hit;
            if (ctrl_wr) begin
                bridge_link_o <= req_i.wdata[1:0];
            end
            // New error pulses win over a clear
            timeout_flags <= (timeout_flags & ~timeout_clr) | timeout_i;
            invalid_flags <= (invalid_flags & ~invalid_clr) | invalid_i;
        end
    end

    assign rsp_o = rsp_q;

endmodule

/* verilog/turf_reg_decode.sv */
`timescale 1ns/1ns
module turf_reg_decode (
    input  logic                    ps_clk,
    input  logic                    reset_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  turf_regs_pkg::wb_addr_t wb_adr_i,
    input  turf_regs_pkg::wb_data_t wb_dat_i,
    input  logic                    done_i,
    output turf_regs_pkg::reg_req_t req_o
);
    import turf_regs_pkg::*;

    logic       busy;
    logic       accept;
    reg_space_e adr_space;
    reg_req_t   req_q;

    // Only one access in flight
    assign accept = wb_stb_i && !busy;

    ////////////////////////////////////////////////////////////
    // Space classification
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (wb_adr_i[CRATE_SEL_BIT]) begin
            adr_space = SPACE_CRATE;
        end else if (wb_adr_i[IDCTL_SEL_MSB:IDCTL_SEL_LSB] == '0) begin
            adr_space = SPACE_IDCTL;
        end else begin
            // Event control, GbE, Aurora and TURFIO control
            adr_space = SPACE_DUMMY;
        end
    end

    ////////////////////////////////////////////////////////////
    // Request register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (accept) begin
            req_q.space <= adr_space;
            req_q.we    <= wb_we_i;
            req_q.addr  <= wb_adr_i;
            req_q.wdata <= wb_dat_i;
        end
        if (reset_i) begin
            busy        <= 1'b0;
            req_q.valid <= 1'b0;
        end else begin
            req_q.valid <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (done_i) begin
                busy <= 1'b0;
            end
        end
    end

    assign req_o = req_q;

    // Each request is acked before the next one goes out
    a_one_in_flight: assert property (
        @(posedge ps_clk) disable iff (reset_i)
        req_o.valid |=> (!req_o.valid throughout done_i[->1])
    );

endmodule

/* verilog/turf_regs_pkg.sv */
package turf_regs_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // Byte address from the processor bridge
    typedef logic [27:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    // Crate space address without the top bus bit
    typedef logic [26:0] crate_addr_t;
    typedef logic [1:0]  bridge_link_t;
    // One bit per TURFIO link
    typedef logic [3:0]  link_mask_t;

    ////////////////////////////////////////////////////////////
    // Address layout
    ////////////////////////////////////////////////////////////

    // Set for anything headed to the crate
    localparam int CRATE_SEL_BIT = 27;
    // Bits 16:14 all zero pick the ID/control space
    localparam int IDCTL_SEL_LSB = 14;
    localparam int IDCTL_SEL_MSB = 16;

    // Word indices inside the ID/control space
    localparam int unsigned REG_IDENT       = 0;
    localparam int unsigned REG_DATEVERSION = 1;
    localparam int unsigned REG_BRIDGE_CTRL = 2;
    localparam int unsigned REG_BRIDGE_STAT = 3;

    ////////////////////////////////////////////////////////////
    // Enums and structs
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        SPACE_IDCTL = 2'd0,
        SPACE_CRATE = 2'd1,
        SPACE_DUMMY = 2'd2
    } reg_space_e;

    typedef enum logic [1:0] {
        BR_IDLE = 2'd0,
        BR_WAIT = 2'd1,
        BR_DONE = 2'd2
    } bridge_state_e;

    // One decoded bus access, valid for a single cycle
    typedef struct packed {
        logic       valid;
        reg_space_e space;
        logic       we;
        wb_addr_t   addr;
        wb_data_t   wdata;
    } reg_req_t;

    typedef struct packed {
        logic     valid;
        wb_data_t rdata;
    } reg_rsp_t;

endpackage
